//--- vlog.f
rtl/sifhPkg.sv
rtl/histRam.sv
rtl/histUpdater.sv
rtl/peakFinder.sv
rtl/histController.sv
rtl/sifhTop.sv
dv/sifhTop_props.sv
dv/sifhTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module sifhTb \
    -Mdir obj_dir -o sifhSim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sifhSim +verilator+error+limit+100 > "$SIM_LOG" 2>&1
simStatus=$?
cat "$SIM_LOG"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "TEST FAILED" "$SIM_LOG"; then
    exit 1
fi
exit 0

//--- dv/sifhTb.sv
`timescale 1ns/100ps

module sifhTb import sifhPkg::*; ();

    logic   clk;
    logic   rstN;
    logic   start;
    logic   frameEnd;
    logic   sampleValid;
    sampleT sample;
    logic   acqReady;
    logic   peakValid;
    peakT   peak;
    logic   runDone;
    logic   busy;

    // reference histogram indexed by pixel and bin
    int refCnt [PIX_NUM][BIN_NUM];

    int seed = 96;
    int errCnt = 0;
    int checkCnt = 0;
    int testCnt = 0;
    int testErrBase = 0;
    // set once any wait runs out so later waits are skipped
    bit hung = 1'b0;

    sifhTop dut (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .frameEnd   (frameEnd),
        .sampleValid(sampleValid),
        .sample     (sample),
        .acqReady   (acqReady),
        .peakValid  (peakValid),
        .peak       (peak),
        .runDone    (runDone),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic void clearModel();
        for (int p = 0; p < PIX_NUM; p++) begin
            for (int b = 0; b < BIN_NUM; b++) begin
                refCnt[p][b] = 0;
            end
        end
    endfunction

    // filler never counts and full scale holds
    function automatic void addToModel(int pix, int ts);
        int bin;
        bin = ts >> (TS_W - BIN_W);
        if ((ts != int'(NO_PHOTON)) && (refCnt[pix][bin] < int'(CNT_MAX))) begin
            refCnt[pix][bin]++;
        end
    endfunction

    task automatic compareField(string name, int expVal, int gotVal);
        checkCnt++;
        assert (expVal == gotVal) else begin
            $display("Error %s expected %0h got %0h", name, expVal, gotVal);
            errCnt++;
        end
    endtask

    task automatic reportTimeout(string what);
        $display("timed out waiting for %s", what);
        errCnt++;
        hung = 1'b1;
    endtask

    // counted is cleared for samples that the DUT has to drop
    task automatic driveSample(int pix, int ts, bit counted);
        @(posedge clk);
        sampleValid <= 1'b1;
        sample.pix  <= PIX_W'(pix);
        sample.ts   <= TS_W'(ts);
        if (counted) begin
            addToModel(pix, ts);
        end
    endtask

    task automatic stopSamples();
        @(posedge clk);
        sampleValid <= 1'b0;
    endtask

    task automatic pulseStart();
        clearModel();
        @(posedge clk);
        sampleValid <= 1'b0;
        start       <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // clear takes 256 cycles
    task automatic waitAcqReady();
        int n = 0;
        if (!hung) begin
            while (!acqReady && (n < 400)) begin
                @(negedge clk);
                n++;
            end
            if (!acqReady) begin
                reportTimeout("acqReady");
            end
        end
    endtask

    task automatic endFrame();
        @(posedge clk);
        sampleValid <= 1'b0;
        frameEnd    <= 1'b1;
        @(posedge clk);
        frameEnd <= 1'b0;
    endtask

    // expected peak per pixel is the lowest bin holding the maximum
    task automatic checkPeaks();
        int bestBin;
        int bestCnt;
        int n;
        for (int p = 0; p < PIX_NUM; p++) begin
            if (hung) begin
                return;
            end
            bestBin = 0;
            bestCnt = refCnt[p][0];
            for (int b = 1; b < BIN_NUM; b++) begin
                if (refCnt[p][b] > bestCnt) begin
                    bestBin = b;
                    bestCnt = refCnt[p][b];
                end
            end
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!peakValid && (n < 200));
            if (!peakValid) begin
                reportTimeout("peakValid");
                return;
            end
            compareField("peak.pix", p, int'(peak.pix));
            compareField("peak.bin", bestBin, int'(peak.bin));
            compareField("peak.cnt", bestCnt, int'(peak.cnt));
            // scan is a busy phase
            compareField("busy", 1, int'(busy));
        end
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!runDone && (n < 10));
        if (!runDone) begin
            reportTimeout("runDone");
        end else begin
            // back in idle right after runDone
            @(negedge clk);
            compareField("busy", 0, int'(busy));
        end
    endtask

    task automatic finishTest(string name);
        testCnt++;
        if (errCnt == testErrBase) begin
            $display("test %0d %s: pass", testCnt, name);
        end else begin
            $display("test %0d %s: %0d errors", testCnt, name, errCnt - testErrBase);
        end
        testErrBase = errCnt;
    endtask

    initial begin
        rstN        = 1'b1;
        start       = 1'b0;
        frameEnd    = 1'b0;
        sampleValid = 1'b0;
        sample      = '0;
        #1;
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        // random pixels and timestamps with the odd filler by chance
        pulseStart();
        waitAcqReady();
        for (int i = 0; i < 300; i++) begin
            driveSample($random(seed) & 3, $random(seed) & 'h3ff, 1'b1);
        end
        endFrame();
        checkPeaks();
        finishTest("random stream");

        // same bin every cycle keeps all stages on one address
        pulseStart();
        waitAcqReady();
        for (int i = 0; i < 20; i++) begin
            driveSample(2, 'h155, 1'b1);
        end
        endFrame();
        checkPeaks();
        finishTest("back-to-back bin");

        pulseStart();
        waitAcqReady();
        for (int i = 0; i < 300; i++) begin
            driveSample(1, 'h070 + (i & 'hf), 1'b1);
        end
        driveSample(1, 'h200, 1'b1);
        endFrame();
        checkPeaks();
        finishTest("saturation");

        // dropped in idle, in clear, as filler and in drain
        for (int i = 0; i < 5; i++) begin
            driveSample(0, 'h200, 1'b0);
        end
        pulseStart();
        // held up to the last clear cycle on the pixel that must stay empty
        for (int i = 0; i < 255; i++) begin
            driveSample(3, 'h3c0, 1'b0);
        end
        stopSamples();
        waitAcqReady();
        for (int i = 0; i < 60; i++) begin
            case (i % 4)
                0: driveSample(3, int'(NO_PHOTON), 1'b1);
                1: driveSample(0, $random(seed) & 'h3ff, 1'b1);
                2: driveSample(1, $random(seed) & 'h3ff, 1'b1);
                default: driveSample(2, int'(NO_PHOTON), 1'b1);
            endcase
        end
        endFrame();
        for (int i = 0; i < 4; i++) begin
            driveSample(0, 'h3f0, 1'b0);
        end
        stopSamples();
        checkPeaks();
        finishTest("ignored samples");

        // pixel 1 sees the higher bin first
        pulseStart();
        waitAcqReady();
        for (int i = 0; i < 5; i++) begin
            driveSample(0, (40 << 4) + 5, 1'b1);
            driveSample(0, 10 << 4, 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            driveSample(1, 50 << 4, 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            driveSample(1, (3 << 4) + 2, 1'b1);
        end
        endFrame();
        checkPeaks();
        finishTest("tie to lower bin");

        pulseStart();
        waitAcqReady();
        driveSample(0, 63 << 4, 1'b1);
        driveSample(0, (63 << 4) + 3, 1'b1);
        driveSample(3, (1 << 4) + 9, 1'b1);
        endFrame();
        checkPeaks();
        finishTest("second run");

        $display("tests %0d checks %0d errors %0d assertion failures %0d",
                 testCnt, checkCnt, errCnt, dut.props.failCnt);
        if ((errCnt == 0) && (dut.props.failCnt == 0)) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- dv/sifhTop_props.sv
`timescale 1ns/100ps

module sifhTopProps import sifhPkg::*; (
    input logic  clk,
    input logic  rstN,
    input logic  frameEnd,
    input logic  acqReady,
    input logic  peakValid,
    input peakT  peak,
    input logic  runDone,
    input logic  busy,
    input ramWrT ramWr
);

    // read back by the testbench summary
    int failCnt = 0;

    // everything quiet while reset is held
    resetIdle: assert property (@(posedge clk)
        !rstN |-> (!acqReady && !peakValid && !runDone && !busy && !ramWr.en))
        else begin
            $error("status outputs or ram write active during reset");
            failCnt++;
        end

    // last pixel peak is followed by runDone
    doneAfterPeak: assert property (@(posedge clk) disable iff (!rstN)
        (peakValid && (peak.pix == PIX_W'(PIX_NUM - 1))) |=> runDone)
        else begin
            $error("runDone missing after last peak");
            failCnt++;
        end

    // and runDone never shows up on its own
    doneHasPeak: assert property (@(posedge clk) disable iff (!rstN)
        runDone |-> $past(peakValid))
        else begin
            $error("runDone without a preceding peak");
            failCnt++;
        end

    // acquisition window closes right after frameEnd
    acqClosed: assert property (@(posedge clk) disable iff (!rstN)
        (acqReady && frameEnd) |=> !acqReady)
        else begin
            $error("acqReady still high after frameEnd");
            failCnt++;
        end

    // busy is low only in idle
    idleNoWrite: assert property (@(posedge clk) disable iff (!rstN)
        !busy |-> !ramWr.en)
        else begin
            $error("ram write enable while idle");
            failCnt++;
        end

endmodule

bind sifhTop sifhTopProps props (
    .clk      (clk),
    .rstN     (rstN),
    .frameEnd (frameEnd),
    .acqReady (acqReady),
    .peakValid(peakValid),
    .peak     (peak),
    .runDone  (runDone),
    .busy     (busy),
    .ramWr    (ramWr)
);

//--- rtl/sifhTop.sv
`timescale 1ns/100ps

module sifhTop import sifhPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   start,
    input  logic   frameEnd,
    input  logic   sampleValid,
    input  sampleT sample,
    output logic   acqReady,
    output logic   peakValid,
    output peakT   peak,
    output logic   runDone,
    output logic   busy
);

    // gated sample path into the updater
    logic   updValid;
    sampleT updSample;

    // updater side of the ram
    logic [ADDR_W-1:0] updRdAddr;
    ramWrT             updWr;
    logic              pipeBusy;

    // scan side
    logic              scanStart;
    logic              scanDone;
    logic [ADDR_W-1:0] scanRdAddr;

    // muxed ram ports
    ramWrT             ramWr;
    logic [ADDR_W-1:0] ramRdAddr;
    logic [CNT_W-1:0]  ramRdData;

    histController ctrl (
        .clk        (clk),
        .rstN       (rstN),
        .start      (start),
        .frameEnd   (frameEnd),
        .sampleValid(sampleValid),
        .sample     (sample),
        .pipeBusy   (pipeBusy),
        .scanDone   (scanDone),
        .updWr      (updWr),
        .updRdAddr  (updRdAddr),
        .scanRdAddr (scanRdAddr),
        .acqReady   (acqReady),
        .busy       (busy),
        .runDone    (runDone),
        .updValid   (updValid),
        .updSample  (updSample),
        .scanStart  (scanStart),
        .ramWr      (ramWr),
        .ramRdAddr  (ramRdAddr)
    );

    histUpdater upd (
        .clk        (clk),
        .rstN       (rstN),
        .sampleValid(updValid),
        .sample     (updSample),
        .rdAddr     (updRdAddr),
        .rdData     (ramRdData),
        .wr         (updWr),
        .pipeBusy   (pipeBusy)
    );

    // read data shared with the updater, only one side listens per phase
    peakFinder finder (
        .clk      (clk),
        .rstN     (rstN),
        .scanStart(scanStart),
        .rdAddr   (scanRdAddr),
        .rdData   (ramRdData),
        .peakValid(peakValid),
        .peak     (peak),
        .scanDone (scanDone)
    );

    histRam ram (
        .clk   (clk),
        .rdAddr(ramRdAddr),
        .rdData(ramRdData),
        .wr    (ramWr)
    );

endmodule

//--- rtl/histController.sv
`timescale 1ns/100ps

module histController import sifhPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              start,
    input  logic              frameEnd,
    input  logic              sampleValid,
    input  sampleT            sample,
    input  logic              pipeBusy,
    input  logic              scanDone,
    input  ramWrT             updWr,
    input  logic [ADDR_W-1:0] updRdAddr,
    input  logic [ADDR_W-1:0] scanRdAddr,
    output logic              acqReady,
    output logic              busy,
    output logic              runDone,
    output logic              updValid,
    output sampleT            updSample,
    output logic              scanStart,
    output ramWrT             ramWr,
    output logic [ADDR_W-1:0] ramRdAddr
);

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(ADDR_NUM - 1);

    ctrlStateT         state;
    ctrlStateT         stateNext;
    logic [ADDR_W-1:0] clrAddr;

    // phase sequencing
    always_comb begin
        stateNext = state;
        case (state)
            ST_IDLE:  if (start) stateNext = ST_CLEAR;
            ST_CLEAR: if (clrAddr == LAST_ADDR) stateNext = ST_ACQ;
            ST_ACQ:   if (frameEnd) stateNext = ST_DRAIN;
            ST_DRAIN: if (!pipeBusy) stateNext = ST_SCAN;
            ST_SCAN:  if (scanDone) stateNext = ST_IDLE;
            default:  stateNext = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= ST_IDLE;
            clrAddr <= '0;
        end else begin
            state <= stateNext;
            // one zero write per cycle, wraps back to 0 at the end
            if (state == ST_CLEAR) begin
                clrAddr <= clrAddr + ADDR_W'(1);
            end else begin
                clrAddr <= '0;
            end
        end
    end

    // status levels
    assign acqReady = (state == ST_ACQ);
    assign busy     = (state != ST_IDLE);
    assign runDone  = (state == ST_SCAN) && scanDone;

    // samples only reach the pipe while acquiring
    assign updValid  = sampleValid && (state == ST_ACQ);
    assign updSample = sample;

    // pipe empty, hand over to the peak scan
    assign scanStart = (state == ST_DRAIN) && !pipeBusy;

    // write port owner by phase
    always_comb begin
        case (state)
            ST_CLEAR: begin
                ramWr.en   = 1'b1;
                ramWr.addr = clrAddr;
                ramWr.cnt  = '0;
            end
            ST_ACQ, ST_DRAIN: ramWr = updWr;
            default:  ramWr = '0;
        endcase
    end

    // read port, scanner only during the scan
    assign ramRdAddr = (state == ST_SCAN) ? scanRdAddr : updRdAddr;

endmodule

//--- rtl/peakFinder.sv
`timescale 1ns/100ps

module peakFinder import sifhPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              scanStart,
    output logic [ADDR_W-1:0] rdAddr,
    input  logic [CNT_W-1:0]  rdData,
    output logic              peakValid,
    output peakT              peak,
    output logic              scanDone
);

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(ADDR_NUM - 1);
    localparam logic [BIN_W-1:0]  LAST_BIN  = BIN_W'(BIN_NUM - 1);

    // read side
    logic              active;
    logic [ADDR_W-1:0] addr;

    // data side, one cycle behind the read side
    logic              dValid;
    logic [ADDR_W-1:0] dAddr;
    logic [BIN_W-1:0]  dBin;
    logic [PIX_W-1:0]  dPix;

    // running maximum of the current pixel
    logic [CNT_W-1:0] bestCnt;
    logic [BIN_W-1:0] bestBin;
    logic [CNT_W-1:0] curCnt;
    logic [BIN_W-1:0] curBin;

    assign rdAddr = addr;
    assign dBin   = dAddr[BIN_W-1:0];
    assign dPix   = dAddr[ADDR_W-1 -: PIX_W];

    // bin 0 restarts the maximum for a new pixel
    // strict compare keeps the lowest bin on ties
    always_comb begin
        if ((dBin == '0) || (rdData > bestCnt)) begin
            curCnt = rdData;
            curBin = dBin;
        end else begin
            curCnt = bestCnt;
            curBin = bestBin;
        end
    end

    // walk all addresses once per scan
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            active   <= 1'b0;
            addr     <= '0;
            dValid   <= 1'b0;
            scanDone <= 1'b0;
        end else begin
            dValid   <= active;
            // done one cycle after the last pixel's peak
            scanDone <= dValid && (dAddr == LAST_ADDR);
            if (scanStart) begin
                active <= 1'b1;
                addr   <= '0;
            end else if (active) begin
                addr <= addr + ADDR_W'(1);
                if (addr == LAST_ADDR) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // address tag and running maximum
    always_ff @(posedge clk) begin
        dAddr <= addr;
        if (dValid) begin
            bestCnt <= curCnt;
            bestBin <= curBin;
        end
    end

    // result on the last bin of each pixel, last bin included
    assign peakValid = dValid && (dBin == LAST_BIN);
    assign peak.pix  = dPix;
    assign peak.bin  = curBin;
    assign peak.cnt  = curCnt;

endmodule

//--- rtl/histUpdater.sv
`timescale 1ns/100ps

module histUpdater import sifhPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              sampleValid,
    input  sampleT            sample,
    output logic [ADDR_W-1:0] rdAddr,
    input  logic [CNT_W-1:0]  rdData,
    output ramWrT             wr,
    output logic              pipeBusy
);

    // entry qualifier, filler timestamps never enter the pipe
    logic inValid;

    // stage 1 waits for the ram data
    logic              s1Valid;
    logic [ADDR_W-1:0] s1Addr;

    // stage 2 holds the incremented count and writes it
    logic              s2Valid;
    logic [ADDR_W-1:0] s2Addr;
    logic [CNT_W-1:0]  s2Cnt;

    // copy of the write from the previous cycle
    // the ram read in stage 1 was issued before that write landed
    logic              s3Valid;
    logic [ADDR_W-1:0] s3Addr;
    logic [CNT_W-1:0]  s3Cnt;

    logic [CNT_W-1:0] baseCnt;
    logic [CNT_W-1:0] nextCnt;

    assign inValid = sampleValid && (sample.ts != NO_PHOTON);

    // address is pixel over the top timestamp bits
    // read issued in the same cycle the sample is accepted
    assign rdAddr = {sample.pix, sample.ts[TS_W-1 -: BIN_W]};

    // pick the freshest count for the stage 1 address
    // the write stage is newer than the held copy, so it goes first
    always_comb begin
        if (s2Valid && (s2Addr == s1Addr)) begin
            baseCnt = s2Cnt;
        end else if (s3Valid && (s3Addr == s1Addr)) begin
            baseCnt = s3Cnt;
        end else begin
            baseCnt = rdData;
        end
    end

    // increment, hold at full scale
    assign nextCnt = (baseCnt == CNT_MAX) ? baseCnt : baseCnt + CNT_W'(1);

    // valid bits
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s1Valid <= inValid;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    // address and count payload
    always_ff @(posedge clk) begin
        s1Addr <= rdAddr;
        s2Addr <= s1Addr;
        s2Cnt  <= nextCnt;
        s3Addr <= s2Addr;
        s3Cnt  <= s2Cnt;
    end

    // write port straight from stage 2
    assign wr.en   = s2Valid;
    assign wr.addr = s2Addr;
    assign wr.cnt  = s2Cnt;

    // held copy is already in the ram, so it does not count as pending
    assign pipeBusy = s1Valid || s2Valid;

endmodule

//--- rtl/histRam.sv
`timescale 1ns/100ps

module histRam import sifhPkg::*; (
    input  logic              clk,
    input  logic [ADDR_W-1:0] rdAddr,
    output logic [CNT_W-1:0]  rdData,
    input  ramWrT             wr
);

    // one count per pixel and bin
    // contents are undefined until the clear phase has run
    logic [CNT_W-1:0] mem [ADDR_NUM];

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.cnt;
        end
    end

    // registered read port, data one cycle after the address
    // same-cycle write to the same address returns the old count
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

endmodule

//--- rtl/sifhPkg.sv
package sifhPkg;

    // timestamp and binning
    localparam int TS_W = 10;
    // bin is the top six timestamp bits
    localparam int BIN_W = 6;
    localparam int BIN_NUM = 2 ** BIN_W;

    // pixel array
    localparam int PIX_NUM = 4;
    localparam int PIX_W = 2;

    // histogram memory, pixel index above bin index
    localparam int ADDR_W = PIX_W + BIN_W;
    localparam int ADDR_NUM = PIX_NUM * BIN_NUM;

    // per-bin counts, saturating
    localparam int CNT_W = 8;
    localparam logic [CNT_W-1:0] CNT_MAX = '1;

    // all-ones timestamp marks an empty slot in the stream
    localparam logic [TS_W-1:0] NO_PHOTON = '1;

    // one incoming sample
    typedef struct packed {
        logic [PIX_W-1:0] pix;
        logic [TS_W-1:0] ts;
    } sampleT;

    // one write into the histogram memory
    typedef struct packed {
        logic en;
        logic [ADDR_W-1:0] addr;
        logic [CNT_W-1:0] cnt;
    } ramWrT;

    // per-pixel peak result
    typedef struct packed {
        logic [PIX_W-1:0] pix;
        logic [BIN_W-1:0] bin;
        logic [CNT_W-1:0] cnt;
    } peakT;

    // run phases of the controller
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_ACQ,
        ST_DRAIN,
        ST_SCAN
    } ctrlStateT;

endpackage
